// ==== Bender.yml ====
package:
  name: graph_aggregate

sources:
  - files:
      - common/agg_pkg.sv
      - common/link_pkg.sv
      - verilog/feature_buffer.sv
      - ingress/record_ingress.sv
      - aggregate_core/aggregate_ctrl.sv
      - aggregate_core/vector_mac.sv
      - verilog/aggregate_top.sv
  - target: test
    files:
      - testbench/tb_aggregate.sv

// ==== aggregate_core/aggregate_ctrl.sv ====
`timescale 1ns/100ps

module aggregate_ctrl (
	input logic clk,
	input logic rst,
	input logic start,
	input agg_pkg::edge_count_t num_vertices,
	input link_pkg::agg_record_t head,
	input logic head_valid,
	output logic pop,
	output agg_pkg::vertex_addr_t src_rd_addr,
	output agg_pkg::mac_issue_t issue,
	input logic run_done,
	output logic busy
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain
	} state_t;

	state_t state;
	agg_pkg::edge_count_t vert_left; // headers not yet popped
	agg_pkg::edge_count_t edges_left; // edges of the current vertex
	agg_pkg::vertex_addr_t cur_dst;
	logic is_header;
	logic take;
	logic term_last;
	logic term_end;

	assign is_header = (head.kind == link_pkg::rec_header);
	assign take = (state == st_run) && head_valid;

	always_comb begin
		if (is_header) begin
			term_last = (head.count == '0);
			term_end = term_last && (vert_left == agg_pkg::edge_count_t'(1));
		end else begin
			term_last = (edges_left == agg_pkg::edge_count_t'(1));
			term_end = term_last && (vert_left == '0);
		end
	end

	// one term per popped record, source read goes out with it
	always_comb begin
		pop = take;
		src_rd_addr = head.addr; // self term reads the destination slot
		issue = '0;
		issue.valid = take;
		issue.first = is_header;
		issue.last = term_last;
		issue.run_end = term_end;
		issue.weight = is_header ? agg_pkg::elem_t'(1) : head.weight;
		issue.dst = is_header ? head.addr : cur_dst;
	end

	assign busy = (state == st_run) || ((state == st_drain) && !run_done);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			vert_left <= '0;
			edges_left <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						vert_left <= num_vertices;
						edges_left <= '0;
						state <= st_run;
					end
				end
				st_run: begin
					if (take) begin
						if (is_header) begin
							vert_left <= vert_left - 1'b1;
							edges_left <= head.count;
						end else begin
							edges_left <= edges_left - 1'b1;
						end
						if (term_end) begin
							state <= st_drain; // wait for the last write
						end
					end
				end
				st_drain: begin
					if (run_done) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take && is_header) begin
			cur_dst <= head.addr;
		end
	end

endmodule

// ==== aggregate_core/vector_mac.sv ====
`timescale 1ns/100ps

module vector_mac (
	input logic clk,
	input logic rst,
	input agg_pkg::mac_issue_t issue,
	input agg_pkg::feature_t src_data,
	output logic dst_we,
	output agg_pkg::vertex_addr_t dst_addr,
	output agg_pkg::feature_t dst_data,
	output logic run_done
);

	agg_pkg::mac_issue_t issue_d; // lines up with the source read data
	agg_pkg::feature_t acc;
	agg_pkg::feature_t acc_next;
	agg_pkg::prod_t prod [agg_pkg::FEAT_LANES];

	always_comb begin
		for (int i = 0; i < agg_pkg::FEAT_LANES; i++) begin
			prod[i] = issue_d.weight * src_data[i];
			if (issue_d.first) begin
				acc_next[i] = prod[i][agg_pkg::ELEM_W-1:0];
			end else begin
				acc_next[i] = acc[i] + prod[i][agg_pkg::ELEM_W-1:0]; // wraps
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			issue_d.valid <= 1'b0;
		end else begin
			issue_d <= issue;
		end
	end

	// partial sums hold while no term arrives
	always_ff @(posedge clk) begin
		if (issue_d.valid) begin
			acc <= acc_next;
		end
		if (issue_d.valid && issue_d.last) begin
			dst_data <= acc_next;
			dst_addr <= issue_d.dst;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dst_we <= 1'b0;
			run_done <= 1'b0;
		end else begin
			dst_we <= issue_d.valid && issue_d.last;
			run_done <= issue_d.valid && issue_d.last && issue_d.run_end;
		end
	end

endmodule

// ==== common/agg_pkg.sv ====
package agg_pkg;

	localparam int NUM_VERTICES = 16; // vertex slots per buffer
	localparam int FEAT_LANES = 4; // elements per feature vector
	localparam int ELEM_W = 16;
	localparam int VADDR_W = $clog2(NUM_VERTICES);
	localparam int COUNT_W = 8;
	localparam int PROD_W = 2 * ELEM_W; // full product before wrapping

	typedef logic [VADDR_W-1:0] vertex_addr_t;
	typedef logic signed [ELEM_W-1:0] elem_t; // feature element or edge weight
	typedef elem_t [FEAT_LANES-1:0] feature_t; // lane 0 in the low bits
	typedef logic [COUNT_W-1:0] edge_count_t;
	typedef logic signed [PROD_W-1:0] prod_t;

	// one term handed from the controller to the multiply-accumulate unit
	typedef struct packed {
		logic valid;
		elem_t weight;
		logic first; // load instead of add
		logic last; // vertex complete after this term
		logic run_end; // last term of the last vertex in the run
		vertex_addr_t dst;
	} mac_issue_t;

endpackage

// ==== common/link_pkg.sv ====
package link_pkg;

	localparam int CREDITS = 4; // receive FIFO depth and sender start credit
	localparam int PTR_W = $clog2(CREDITS);
	localparam int CNT_W = $clog2(CREDITS + 1);

	typedef enum logic {
		rec_header = 1'b0,
		rec_edge = 1'b1
	} record_kind_t;

	// header: addr is the destination, count the neighbor count
	// edge: addr is the source vertex, weight its coefficient
	typedef struct packed {
		record_kind_t kind;
		agg_pkg::vertex_addr_t addr;
		agg_pkg::edge_count_t count;
		agg_pkg::elem_t weight;
	} agg_record_t;

endpackage

// ==== files.f ====
common/agg_pkg.sv
common/link_pkg.sv
verilog/feature_buffer.sv
ingress/record_ingress.sv
aggregate_core/aggregate_ctrl.sv
aggregate_core/vector_mac.sv
verilog/aggregate_top.sv
testbench/tb_aggregate.sv

// ==== ingress/record_ingress.sv ====
`timescale 1ns/100ps

module record_ingress (
	input logic clk,
	input logic rst,
	input logic rec_valid,
	input link_pkg::agg_record_t rec,
	input logic pop,
	output link_pkg::agg_record_t head,
	output logic head_valid,
	output logic credit_return
);

	link_pkg::agg_record_t mem [link_pkg::CREDITS];
	logic [link_pkg::PTR_W-1:0] wr_ptr;
	logic [link_pkg::PTR_W-1:0] rd_ptr;
	logic [link_pkg::CNT_W-1:0] count;
	logic do_pop;

	assign head = mem[rd_ptr];
	assign head_valid = (count != '0);
	assign do_pop = pop && head_valid;

	always_ff @(posedge clk) begin
		if (rec_valid) begin
			mem[wr_ptr] <= rec; // sender credit guarantees a free slot
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= do_pop; // one credit back per popped record
			if (rec_valid) begin
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({rec_valid, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== testbench/tb_aggregate.sv ====
`timescale 1ns/100ps

module tb_aggregate;

	localparam int NUM_STEPS = 20;
	localparam int NUM_RUNS = 3;
	localparam int LIMIT = 200 * NUM_STEPS + 100;

	typedef struct packed {
		logic [1:0] run;
		link_pkg::record_kind_t kind;
		agg_pkg::vertex_addr_t addr;
		agg_pkg::edge_count_t count;
		agg_pkg::elem_t weight;
	} step_t;

	logic clk;
	logic rst;
	logic start;
	agg_pkg::edge_count_t num_vertices;
	logic rec_valid;
	link_pkg::agg_record_t rec;
	logic credit_return;
	logic load_we;
	agg_pkg::vertex_addr_t load_addr;
	agg_pkg::feature_t load_data;
	agg_pkg::vertex_addr_t rd_addr;
	agg_pkg::feature_t rd_data;
	logic busy;
	logic done;

	step_t steps [NUM_STEPS];
	agg_pkg::feature_t src_mem [agg_pkg::NUM_VERTICES]; // model of the source buffer
	agg_pkg::feature_t exp_mem [agg_pkg::NUM_VERTICES];
	logic written [agg_pkg::NUM_VERTICES]; // destination slots with a known value
	integer seed = 32'h599b;
	int n_steps = 0;
	int cycles = 0;
	int credits;
	int returned;
	logic in_run;

	aggregate_top dut_i (
		.clk(clk), .rst(rst), .start(start), .num_vertices(num_vertices),
		.rec_valid(rec_valid), .rec(rec), .credit_return(credit_return),
		.load_we(load_we), .load_addr(load_addr), .load_data(load_data),
		.rd_addr(rd_addr), .rd_data(rd_data), .busy(busy), .done(done)
	);

	task automatic abort(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			abort($sformatf("Error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic add_step(input int run, input link_pkg::record_kind_t kind, input int addr,
			input int count, input int weight);
		steps[n_steps] = {2'(run), kind, agg_pkg::vertex_addr_t'(addr),
			agg_pkg::edge_count_t'(count), agg_pkg::elem_t'(weight)};
		n_steps++;
	endtask

	// self feature plus weight times neighbor, each element wrapped to 16 bits
	function automatic agg_pkg::feature_t ref_vertex(input int h);
		agg_pkg::feature_t f;
		int p;
		f = src_mem[steps[h].addr];
		for (int k = 1; k <= int'(steps[h].count); k++) begin
			for (int l = 0; l < agg_pkg::FEAT_LANES; l++) begin
				p = int'(steps[h + k].weight) * int'(src_mem[steps[h + k].addr][l]);
				f[l] = f[l] + agg_pkg::elem_t'(p);
			end
		end
		return f;
	endfunction

	// one clock, outputs sampled at the falling edge
	task automatic tick();
		@(negedge clk);
		if (credit_return) begin
			credits++;
			returned++;
			if (credits > link_pkg::CREDITS) abort("credit returned with no record outstanding");
		end
		check("busy", busy, in_run && !done);
		if (done) begin
			if (!in_run) abort("done pulsed outside a run");
			in_run = 1'b0;
		end
	endtask

	task automatic load_sources();
		for (int a = 0; a < agg_pkg::NUM_VERTICES; a++) begin
			src_mem[a] = {$random(seed), $random(seed)};
			load_we = 1'b1;
			load_addr = agg_pkg::vertex_addr_t'(a);
			load_data = src_mem[a];
			tick();
		end
		load_we = 1'b0;
	endtask

	task automatic read_back();
		for (int a = 0; a < agg_pkg::NUM_VERTICES; a++) begin
			rd_addr = agg_pkg::vertex_addr_t'(a);
			tick();
			if (written[a]) check($sformatf("rd_data[%0d]", a), rd_data, exp_mem[a]);
		end
	endtask

	task automatic do_run(input int run);
		int first;
		int n;
		int n_vert;
		int sent;
		int gap;
		logic started;
		logic early;
		first = -1;
		n = 0;
		n_vert = 0;
		for (int i = 0; i < n_steps; i++) begin
			if (steps[i].run == run) begin
				if (first < 0) first = i;
				n++;
				if (steps[i].kind == link_pkg::rec_header) n_vert++;
			end
		end
		early = (run == NUM_RUNS - 1); // last run fills the FIFO before start
		started = 1'b0;
		sent = 0;
		gap = 0;
		returned = 0;
		while (sent < n || !started) begin
			if (!started && (!early || credits == 0 || sent == n)) begin
				start = 1'b1;
				num_vertices = agg_pkg::edge_count_t'(n_vert);
				started = 1'b1;
				in_run = 1'b1;
			end
			rec_valid = 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (sent < n && credits > 0) begin
				rec_valid = 1'b1;
				rec = {steps[first + sent].kind, steps[first + sent].addr,
					steps[first + sent].count, steps[first + sent].weight};
				credits--;
				sent++;
				gap = early ? 0 : ($random(seed) & 3);
			end
			tick();
			start = 1'b0;
		end
		rec_valid = 1'b0;
		while (in_run) tick();
		tick(); // last destination write lands at the end of the done cycle
		check("credit_return count", returned, n);
		for (int i = first; i < first + n; i++) begin
			if (steps[i].kind == link_pkg::rec_header) begin
				exp_mem[steps[i].addr] = ref_vertex(i);
				written[steps[i].addr] = 1'b1;
			end
		end
		read_back();
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) abort("timeout, the test did not finish within the cycle limit");
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		num_vertices = '0;
		rec_valid = 1'b0;
		rec = '0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		rd_addr = '0;
		credits = link_pkg::CREDITS;
		returned = 0;
		in_run = 1'b0;
		for (int a = 0; a < agg_pkg::NUM_VERTICES; a++) written[a] = 1'b0;
		add_step(0, link_pkg::rec_header, 2, 2, 0);
		add_step(0, link_pkg::rec_edge, 5, 0, 3);
		add_step(0, link_pkg::rec_edge, 7, 0, -2);
		add_step(0, link_pkg::rec_header, 9, 0, 0); // self term only
		add_step(0, link_pkg::rec_header, 4, 3, 0);
		add_step(0, link_pkg::rec_edge, 1, 0, 32767);
		add_step(0, link_pkg::rec_edge, 4, 0, -1);
		add_step(0, link_pkg::rec_edge, 15, 0, 100);
		add_step(1, link_pkg::rec_header, 4, 1, 0); // overwrites vertex 4
		add_step(1, link_pkg::rec_edge, 0, 0, -5);
		add_step(1, link_pkg::rec_header, 11, 2, 0);
		add_step(1, link_pkg::rec_edge, 2, 0, 2);
		add_step(1, link_pkg::rec_edge, 2, 0, 7);
		add_step(2, link_pkg::rec_header, 0, 6, 0);
		add_step(2, link_pkg::rec_edge, 3, 0, -32768);
		add_step(2, link_pkg::rec_edge, 6, 0, 1);
		add_step(2, link_pkg::rec_edge, 8, 0, -7);
		add_step(2, link_pkg::rec_edge, 10, 0, 12);
		add_step(2, link_pkg::rec_edge, 13, 0, 255);
		add_step(2, link_pkg::rec_edge, 14, 0, -300);
		repeat (5) @(negedge clk);
		rst = 1'b0;
		check("busy", busy, 0);
		check("done", done, 0);
		check("credit_return", credit_return, 0);
		repeat (4) tick(); // idle, no credit may come back
		for (int r = 0; r < NUM_RUNS; r++) begin
			load_sources();
			do_run(r);
		end
		$display("sim passed");
		$finish;
	end

endmodule

// ==== verilog/aggregate_top.sv ====
`timescale 1ns/100ps

module aggregate_top (
	input logic clk,
	input logic rst,
	input logic start,
	input agg_pkg::edge_count_t num_vertices,
	input logic rec_valid,
	input link_pkg::agg_record_t rec,
	output logic credit_return,
	input logic load_we,
	input agg_pkg::vertex_addr_t load_addr,
	input agg_pkg::feature_t load_data,
	input agg_pkg::vertex_addr_t rd_addr,
	output agg_pkg::feature_t rd_data,
	output logic busy,
	output logic done
);

	link_pkg::agg_record_t head;
	logic head_valid;
	logic pop;
	agg_pkg::vertex_addr_t src_rd_addr;
	agg_pkg::feature_t src_data;
	agg_pkg::mac_issue_t issue;
	logic dst_we;
	agg_pkg::vertex_addr_t dst_addr;
	agg_pkg::feature_t dst_data;

	record_ingress ingress_i (
		.clk(clk),
		.rst(rst),
		.rec_valid(rec_valid),
		.rec(rec),
		.pop(pop),
		.head(head),
		.head_valid(head_valid),
		.credit_return(credit_return)
	);

	aggregate_ctrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.num_vertices(num_vertices),
		.head(head),
		.head_valid(head_valid),
		.pop(pop),
		.src_rd_addr(src_rd_addr),
		.issue(issue),
		.run_done(done),
		.busy(busy)
	);

	feature_buffer src_buf_i ( // written only through the load port
		.clk(clk),
		.we(load_we),
		.wr_addr(load_addr),
		.wr_data(load_data),
		.rd_addr(src_rd_addr),
		.rd_data(src_data)
	);

	vector_mac mac_i (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.src_data(src_data),
		.dst_we(dst_we),
		.dst_addr(dst_addr),
		.dst_data(dst_data),
		.run_done(done)
	);

	feature_buffer dst_buf_i ( // read side is the readout port
		.clk(clk),
		.we(dst_we),
		.wr_addr(dst_addr),
		.wr_data(dst_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

// ==== verilog/feature_buffer.sv ====
`timescale 1ns/100ps

module feature_buffer (
	input logic clk,
	input logic we,
	input agg_pkg::vertex_addr_t wr_addr,
	input agg_pkg::feature_t wr_data,
	input agg_pkg::vertex_addr_t rd_addr,
	output agg_pkg::feature_t rd_data
);

	agg_pkg::feature_t mem [agg_pkg::NUM_VERTICES];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, old data on a same-cycle write to the same slot
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule
